//--- common/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_XLEN  32 // Data and pc width
`define CORE_NREGS 32 // General registers incl. r0

// ALU operation codes
`define ALU_OP_W 4
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLT  4'd2
`define ALU_SLTU 4'd3
`define ALU_AND  4'd4
`define ALU_OR   4'd5
`define ALU_XOR  4'd6
`define ALU_NOR  4'd7
`define ALU_LUI  4'd8 // Pass src_b

// 3R forms, instr[31:15]
`define OPC_ADD_W  17'h00020
`define OPC_SUB_W  17'h00022
`define OPC_SLT    17'h00024
`define OPC_SLTU   17'h00025
`define OPC_NOR    17'h00028
`define OPC_AND    17'h00029
`define OPC_OR     17'h0002a
`define OPC_XOR    17'h0002b

// 2RI12 forms, instr[31:22]
`define OPC_SLTI   10'h008
`define OPC_ADDI_W 10'h00a
`define OPC_ANDI   10'h00d
`define OPC_ORI    10'h00e
`define OPC_XORI   10'h00f

`define OPC_LU12I_W 7'h0a // instr[31:25]

`endif

//--- common/core_pkg.sv
`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]          word_t;
    typedef logic [31:0]                    instr_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;
    typedef logic [`ALU_OP_W-1:0]           alu_op_t;

    // Testbench to decode
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } fetch_t;

    // Decode to execute, operands already resolved
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src_a;
        word_t     src_b;
        reg_addr_t rd;
        logic      we;    // Low for r0 and unknown encodings
    } dec_ex_t;

    // Register write, also used as a forwarding source
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } ex_res_t;

    // Debug commit record
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } commit_t;

endpackage

//--- flist.f
+incdir+common
+incdir+test
common/core_pkg.sv
logic/regfile.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/result_stage.sv
logic/cpu_core.sv
test/tb_cpu_core.sv

//--- logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic              clk,
    input  logic              rst_n_i,
    input  core_pkg::fetch_t  fetch_i,
    output core_pkg::commit_t commit_o,
    output core_pkg::word_t   retired_o
);
    import core_pkg::*;

    reg_addr_t  rf_raddr_a;
    reg_addr_t  rf_raddr_b;
    word_t      rf_rdata_a;
    word_t      rf_rdata_b;
    dec_ex_t    dec_ex;
    reg_write_t ex_fwd;   // Combinational, execute stage
    ex_res_t    ex_res;
    reg_write_t wb_wr;    // Register write and second forward

    decode_stage u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_i      (fetch_i),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb_wr),
        .dec_o        (dec_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .dec_i    (dec_ex),
        .ex_fwd_o (ex_fwd),
        .res_o    (ex_res)
    );

    result_stage u_result (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .res_i     (ex_res),
        .rf_wr_o   (wb_wr),
        .commit_o  (commit_o),
        .retired_o (retired_o)
    );

    regfile u_regfile (
        .clk       (clk),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .wr_i      (wb_wr)
    );

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "core_params.svh"

module regfile (
    input  logic                 clk,
    input  core_pkg::reg_addr_t  raddr_a_i,
    input  core_pkg::reg_addr_t  raddr_b_i,
    output core_pkg::word_t      rdata_a_o,
    output core_pkg::word_t      rdata_b_o,
    input  core_pkg::reg_write_t wr_i
);

    // r0 has no storage
    core_pkg::word_t regs [1:`CORE_NREGS-1];

    always_ff @(posedge clk) begin
        if (wr_i.we && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // No bypass here, decode forwards from both later stages
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- pipeline/decode_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  core_pkg::fetch_t     fetch_i,
    output core_pkg::reg_addr_t  rf_raddr_a_o,
    output core_pkg::reg_addr_t  rf_raddr_b_o,
    input  core_pkg::word_t      rf_rdata_a_i,
    input  core_pkg::word_t      rf_rdata_b_i,
    input  core_pkg::reg_write_t ex_fwd_i,
    input  core_pkg::reg_write_t wb_fwd_i,
    output core_pkg::dec_ex_t    dec_o
);
    import core_pkg::*;

    instr_t    instr;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    alu_op_t   alu_op;
    word_t     imm_b;
    logic      use_imm;
    logic      is_known;
    word_t     opnd_a;
    word_t     opnd_b;
    dec_ex_t   dec_q;

    // Youngest producer wins
    function automatic word_t fwd_pick(reg_addr_t addr, word_t rf_data,
                                       reg_write_t ex_w, reg_write_t wb_w);
        if (ex_w.we && ex_w.rd != '0 && ex_w.rd == addr) begin
            return ex_w.data;
        end
        if (wb_w.we && wb_w.rd != '0 && wb_w.rd == addr) begin
            return wb_w.data;
        end
        return rf_data;
    endfunction

    assign instr = fetch_i.instr;
    assign rd    = instr[4:0];
    assign rj    = instr[9:5];
    assign rk    = instr[14:10]; // Part of the immediate for 2RI12

    assign rf_raddr_a_o = rj;
    assign rf_raddr_b_o = rk;

    always_comb begin
        alu_op   = `ALU_ADD;
        imm_b    = '0;
        use_imm  = 1'b0;
        is_known = 1'b1;
        if (instr[31:25] == `OPC_LU12I_W) begin
            alu_op  = `ALU_LUI;
            imm_b   = {instr[24:5], 12'b0};
            use_imm = 1'b1;
        end else begin
            case (instr[31:22])
                `OPC_ADDI_W,
                `OPC_SLTI: begin
                    alu_op  = (instr[31:22] == `OPC_SLTI) ? `ALU_SLT : `ALU_ADD;
                    imm_b   = {{20{instr[21]}}, instr[21:10]}; // Sign extend
                    use_imm = 1'b1;
                end
                `OPC_ANDI,
                `OPC_ORI,
                `OPC_XORI: begin
                    imm_b   = {20'b0, instr[21:10]}; // Zero extend
                    use_imm = 1'b1;
                    case (instr[31:22])
                        `OPC_ANDI: alu_op = `ALU_AND;
                        `OPC_ORI:  alu_op = `ALU_OR;
                        default:   alu_op = `ALU_XOR;
                    endcase
                end
                default: begin
                    case (instr[31:15])
                        `OPC_ADD_W: alu_op = `ALU_ADD;
                        `OPC_SUB_W: alu_op = `ALU_SUB;
                        `OPC_SLT:   alu_op = `ALU_SLT;
                        `OPC_SLTU:  alu_op = `ALU_SLTU;
                        `OPC_AND:   alu_op = `ALU_AND;
                        `OPC_OR:    alu_op = `ALU_OR;
                        `OPC_XOR:   alu_op = `ALU_XOR;
                        `OPC_NOR:   alu_op = `ALU_NOR;
                        default:    is_known = 1'b0; // Retires without a write
                    endcase
                end
            endcase
        end
    end

    assign opnd_a = fwd_pick(rj, rf_rdata_a_i, ex_fwd_i, wb_fwd_i);
    assign opnd_b = use_imm ? imm_b : fwd_pick(rk, rf_rdata_b_i, ex_fwd_i, wb_fwd_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q.valid <= fetch_i.valid;
        end
        if (fetch_i.valid) begin
            dec_q.pc     <= fetch_i.pc;
            dec_q.alu_op <= alu_op;
            dec_q.src_a  <= opnd_a;
            dec_q.src_b  <= opnd_b;
            dec_q.rd     <= rd;
            dec_q.we     <= is_known && (rd != '0);
        end
    end

    assign dec_o = dec_q;

endmodule

//--- pipeline/execute_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  core_pkg::dec_ex_t    dec_i,
    output core_pkg::reg_write_t ex_fwd_o,
    output core_pkg::ex_res_t    res_o
);
    import core_pkg::*;

    word_t   alu_res;
    logic    lt_s;
    logic    lt_u;
    ex_res_t res_q;

    assign lt_s = $signed(dec_i.src_a) < $signed(dec_i.src_b);
    assign lt_u = dec_i.src_a < dec_i.src_b;

    always_comb begin
        case (dec_i.alu_op)
            `ALU_ADD:  alu_res = dec_i.src_a + dec_i.src_b;
            `ALU_SUB:  alu_res = dec_i.src_a - dec_i.src_b;
            `ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, lt_s};
            `ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, lt_u};
            `ALU_AND:  alu_res = dec_i.src_a & dec_i.src_b;
            `ALU_OR:   alu_res = dec_i.src_a | dec_i.src_b;
            `ALU_XOR:  alu_res = dec_i.src_a ^ dec_i.src_b;
            `ALU_NOR:  alu_res = ~(dec_i.src_a | dec_i.src_b);
            `ALU_LUI:  alu_res = dec_i.src_b; // Immediate already shifted
            default:   alu_res = '0;
        endcase
    end

    // Forward the instruction held now
    assign ex_fwd_o.we   = dec_i.valid & dec_i.we;
    assign ex_fwd_o.rd   = dec_i.rd;
    assign ex_fwd_o.data = alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q.valid <= dec_i.valid;
        end
        if (dec_i.valid) begin
            res_q.pc   <= dec_i.pc;
            res_q.we   <= dec_i.we;
            res_q.rd   <= dec_i.rd;
            res_q.data <= alu_res;
        end
    end

    assign res_o = res_q;

endmodule

//--- pipeline/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  core_pkg::ex_res_t    res_i,
    output core_pkg::reg_write_t rf_wr_o,
    output core_pkg::commit_t    commit_o,
    output core_pkg::word_t      retired_o
);
    import core_pkg::*;

    commit_t commit_q;
    word_t   retired_q;

    // Also the second forwarding source
    assign rf_wr_o.we   = res_i.valid & res_i.we;
    assign rf_wr_o.rd   = res_i.rd;
    assign rf_wr_o.data = res_i.data;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_q.valid <= 1'b0;
        end else begin
            commit_q.valid <= res_i.valid;
        end
        if (res_i.valid) begin
            commit_q.pc    <= res_i.pc;
            commit_q.wen   <= res_i.we;
            commit_q.wnum  <= res_i.rd;
            commit_q.wdata <= res_i.data;
        end
    end

    // Counts every retirement, write or not
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retired_q <= '0;
        end else if (res_i.valid) begin
            retired_q <= retired_q + 1'b1;
        end
    end

    assign commit_o  = commit_q;
    assign retired_o = retired_q;

endmodule

//--- test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Operation kinds, 3R first, then immediate forms
localparam int OP_ADD   = 0;
localparam int OP_SUB   = 1;
localparam int OP_SLT   = 2;
localparam int OP_SLTU  = 3;
localparam int OP_AND   = 4;
localparam int OP_OR    = 5;
localparam int OP_XOR   = 6;
localparam int OP_NOR   = 7;
localparam int OP_ADDI  = 8;
localparam int OP_SLTI  = 9;
localparam int OP_ANDI  = 10;
localparam int OP_ORI   = 11;
localparam int OP_XORI  = 12;
localparam int OP_LU12I = 13;
localparam int OP_BAD   = 14; // No valid encoding

logic [31:0] lcg_state = 32'h459e_45e8;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    logic [31:0] v;
    v = lcg_next();
    return (v >> 8) % n; // Low LCG bits are weak
endfunction

function automatic logic [19:0] rand_imm();
    logic [31:0] v;
    v = lcg_next();
    return v[27:8];
endfunction

function automatic logic [31:0] encode(input int op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic [19:0] imm);
    case (op)
        OP_ADD:   return {`OPC_ADD_W, rk, rj, rd};
        OP_SUB:   return {`OPC_SUB_W, rk, rj, rd};
        OP_SLT:   return {`OPC_SLT, rk, rj, rd};
        OP_SLTU:  return {`OPC_SLTU, rk, rj, rd};
        OP_AND:   return {`OPC_AND, rk, rj, rd};
        OP_OR:    return {`OPC_OR, rk, rj, rd};
        OP_XOR:   return {`OPC_XOR, rk, rj, rd};
        OP_NOR:   return {`OPC_NOR, rk, rj, rd};
        OP_ADDI:  return {`OPC_ADDI_W, imm[11:0], rj, rd};
        OP_SLTI:  return {`OPC_SLTI, imm[11:0], rj, rd};
        OP_ANDI:  return {`OPC_ANDI, imm[11:0], rj, rd};
        OP_ORI:   return {`OPC_ORI, imm[11:0], rj, rd};
        OP_XORI:  return {`OPC_XORI, imm[11:0], rj, rd};
        OP_LU12I: return {`OPC_LU12I_W, imm, rd};
        default:  return {17'h1ffff, rk, rj, rd}; // Matches no opcode
    endcase
endfunction

// Expected write value from the architectural rules
function automatic logic [31:0] ref_value(input int op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [19:0] imm);
    logic [31:0] sx;
    logic [31:0] zx;
    sx = {{20{imm[11]}}, imm[11:0]};
    zx = {20'b0, imm[11:0]};
    case (op)
        OP_ADD:   return a + b;
        OP_SUB:   return a - b;
        OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
        OP_AND:   return a & b;
        OP_OR:    return a | b;
        OP_XOR:   return a ^ b;
        OP_NOR:   return ~(a | b);
        OP_ADDI:  return a + sx;
        OP_SLTI:  return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
        OP_ANDI:  return a & zx;
        OP_ORI:   return a | zx;
        OP_XORI:  return a ^ zx;
        OP_LU12I: return {imm, 12'b0};
        default:  return 32'd0;
    endcase
endfunction

`endif

//--- test/tb_cpu_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module tb_cpu_core;
    import core_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_GAP      = 3;
    localparam int N_TOTAL      = 62 + 300 + 120 + 180 + 30; // All issued instructions
    localparam int LIMIT        = RESET_CYCLES + N_TOTAL * (1 + MAX_GAP) + 50;

    typedef struct packed {
        logic [31:0] cycle; // Cycle the commit is due
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } exp_t;

    logic        clk;
    logic        rst_n_i;
    fetch_t      fetch_i;
    commit_t     commit_o;
    word_t       retired_o;

    logic [31:0] model_regs [0:31];
    exp_t        exp_q [$];
    exp_t        e_cur;
    logic [31:0] pc;
    int          cycle;
    int          issued;
    int          commits;
    int          errors;

    `include "tb_ref_model.svh"

    cpu_core i_cpu_core (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .fetch_i   (fetch_i),
        .commit_o  (commit_o),
        .retired_o (retired_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic issue(input int op, input logic [4:0] rd, input logic [4:0] rj,
                         input logic [4:0] rk, input logic [19:0] imm);
        exp_t e;
        @(posedge clk);
        #2;
        fetch_i.valid = 1'b1;
        fetch_i.pc    = pc;
        fetch_i.instr = encode(op, rd, rj, rk, imm);
        e.cycle = cycle + 3; // Decode, execute and result registers
        e.pc    = pc;
        e.wen   = (op != OP_BAD) && (rd != 5'd0);
        e.wnum  = rd;
        e.wdata = ref_value(op, model_regs[rj], model_regs[rk], imm);
        exp_q.push_back(e);
        if (e.wen) begin
            model_regs[rd] = e.wdata; // Program order update
        end
        pc = pc + 32'd4;
        issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            fetch_i.valid = 1'b0;
        end
    endtask

    task automatic maybe_gap();
        if (rand_below(4) == 0) begin
            idle(1 + rand_below(MAX_GAP));
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("Timeout after %0d cycles, %0d commits still missing", cycle, exp_q.size());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Compare process sampling mid cycle
    always @(negedge clk) begin
        if (!rst_n_i && cycle >= 1) begin
            check_value("commit valid in reset", commit_o.valid, 32'd0);
            check_value("retired in reset", retired_o, 32'd0);
        end else if (rst_n_i && commit_o.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Commit at cycle %0d with no instruction outstanding", cycle);
            end else begin
                e_cur = exp_q.pop_front();
                commits++;
                check_value("commit cycle", cycle, e_cur.cycle);
                check_value("commit pc", commit_o.pc, e_cur.pc);
                check_value("commit wen", commit_o.wen, e_cur.wen);
                check_value("commit wnum", commit_o.wnum, e_cur.wnum);
                if (e_cur.wen) begin
                    check_value("commit wdata", commit_o.wdata, e_cur.wdata);
                end
                check_value("retired count", retired_o, commits);
            end
        end else if (rst_n_i && exp_q.size() != 0 && exp_q[0].cycle <= cycle) begin
            e_cur = exp_q.pop_front(); // Drop it to stay aligned
            errors++;
            $display("Commit for pc %h missing in cycle %0d", e_cur.pc, cycle);
        end
    end

    initial begin
        int i;
        int d;
        int g;
        int k;
        logic [4:0] rx;
        rst_n_i = 1'b0;
        fetch_i = '0;
        pc      = 32'h1c00_0000;
        cycle   = 0;
        issued  = 0;
        commits = 0;
        errors  = 0;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // Full 32-bit value in every register
        for (i = 1; i < 32; i++) begin
            issue(OP_LU12I, i, 0, 0, rand_imm());
            issue(OP_ORI, i, i, 0, rand_imm());
        end
        for (k = 0; k < 300; k++) begin
            issue(rand_below(8), 1 + rand_below(31), rand_below(32), rand_below(32), 0);
            maybe_gap();
        end
        for (k = 0; k < 120; k++) begin
            issue(OP_ADDI + rand_below(6), 1 + rand_below(31), rand_below(32), 0, rand_imm());
            maybe_gap();
        end

        // Producer, d-1 fillers, consumer
        for (d = 1; d <= 3; d++) begin
            for (g = 0; g < 2; g++) begin
                for (k = 0; k < 10; k++) begin
                    rx = 1 + rand_below(31);
                    issue(rand_below(14), rx, rand_below(32), rand_below(32), rand_imm());
                    if (g != 0) idle(1);
                    for (i = 1; i < d; i++) begin
                        issue(OP_XOR, (rx % 31) + 1, rand_below(32), rand_below(32), 0);
                        if (g != 0) idle(1);
                    end
                    issue(rand_below(8), 1 + rand_below(31), rx, rx, 0);
                    if (g != 0) idle(1);
                end
            end
        end

        for (k = 0; k < 10; k++) begin
            issue(rand_below(14), 0, rand_below(32), rand_below(32), rand_imm());
            issue(OP_NOR, 1 + rand_below(31), 0, 0, 0); // All ones if r0 stayed zero
            issue(OP_BAD, rand_below(32), rand_below(32), rand_below(32), 0);
        end
        idle(1);

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(negedge clk); // Room for a stray commit
        check_value("final retired count", retired_o, issued);

        $display("Issued %0d, committed %0d, errors %0d", issued, commits, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
